//--- common/noc_pkg.sv
package noc_pkg;

    // node address, 16 nodes
    typedef logic [3:0] node_id_t;

    localparam int NUM_NODES = 1 << $bits(node_id_t);

    // status counter
    typedef logic [15:0] drop_count_t;

    typedef enum logic [1:0] {
        DATA      = 2'b00,
        ROUTE_ADD = 2'b01
    } flit_kind_e;

    typedef struct packed {
        flit_kind_e   kind;
        node_id_t     src;
        node_id_t     dst;
        logic [15:0]  payload;
    } flit_t;

    // arrival channel data, tagged with the sending neighbor
    typedef struct packed {
        flit_t    flit;
        node_id_t from_node;
    } arrival_t;

    typedef struct packed {
        logic     valid;
        node_id_t next_hop;
    } route_entry_t;

    typedef struct packed {
        flit_t    flit;
        node_id_t next_hop;
    } routed_flit_t;

    // one-cycle neighbor expiry event
    typedef struct packed {
        logic     valid;
        node_id_t neighbor;
    } expire_t;

endpackage

//--- route/route_table.sv
`timescale 1ns/1ns

module route_table (
    input  logic                  nocclk,
    input  logic                  rst_n,

    input  noc_pkg::node_id_t     lookup_key,
    output noc_pkg::route_entry_t route,

    input  noc_pkg::route_entry_t learn,
    input  noc_pkg::node_id_t     learn_dst,

    input  noc_pkg::expire_t      expire
);

    logic [noc_pkg::NUM_NODES-1:0] entry_valid;
    noc_pkg::node_id_t             next_hop_q [noc_pkg::NUM_NODES];

    // lookup, same cycle
    always_comb begin
        route.valid = entry_valid[lookup_key];
        route.next_hop = next_hop_q[lookup_key];
    end

    //////////////////////////////
    // learn and invalidate
    //////////////////////////////

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else begin
            for (int i = 0; i < noc_pkg::NUM_NODES; i++) begin
                if (expire.valid) begin
                    // drop every route through the dead neighbor
                    if (next_hop_q[i] == expire.neighbor) begin
                        entry_valid[i] <= 1'b0;
                    end
                end else if (learn.valid && learn_dst == noc_pkg::node_id_t'(i)) begin
                    entry_valid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge nocclk) begin
        if (learn.valid && !expire.valid) begin
            next_hop_q[learn_dst] <= learn.next_hop;
        end
    end

    // the pipeline is stalled during an expiry
    a_learn_vs_expire: assert property (@(posedge nocclk) disable iff (!rst_n)
        !(learn.valid && expire.valid))
        else $error("route learn during neighbor expiry");

endmodule

//--- route/neighbor_monitor.sv
`timescale 1ns/1ns

module neighbor_monitor #(
    parameter int EXPIRE_CYCLES = 200,
    parameter int MAX_NEIGHBORS = 8
) (
    input  logic              nocclk,
    input  logic              rst_n,

    input  noc_pkg::node_id_t seen,
    input  logic              seen_valid,

    output noc_pkg::expire_t  expire
);

    localparam int TW = $clog2(EXPIRE_CYCLES + 1);
    localparam int SW = (MAX_NEIGHBORS > 1) ? $clog2(MAX_NEIGHBORS) : 1;
    localparam logic [TW-1:0] TIMER_MAX = TW'(EXPIRE_CYCLES);

    logic [MAX_NEIGHBORS-1:0] slot_valid;
    noc_pkg::node_id_t        slot_id [MAX_NEIGHBORS];
    logic [TW-1:0]            slot_timer [MAX_NEIGHBORS];

    logic [MAX_NEIGHBORS-1:0] hit;
    logic [MAX_NEIGHBORS-1:0] due;
    logic                     any_hit;
    logic                     free_found;
    logic [SW-1:0]            free_slot;
    logic                     exp_found;
    logic [SW-1:0]            exp_slot;
    logic                     do_register;

    always_comb begin
        any_hit = 1'b0;
        free_found = 1'b0;
        free_slot = '0;
        exp_found = 1'b0;
        exp_slot = '0;
        for (int i = 0; i < MAX_NEIGHBORS; i++) begin
            hit[i] = slot_valid[i] && slot_id[i] == seen;
            // a sighting this cycle keeps the neighbor alive
            due[i] = slot_valid[i] && slot_timer[i] == TIMER_MAX && !(seen_valid && hit[i]);
            any_hit = any_hit || hit[i];
        end
        // downward scan, lowest slot wins
        for (int i = MAX_NEIGHBORS - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_found = 1'b1;
                free_slot = SW'(i);
            end
            if (due[i]) begin
                exp_found = 1'b1;
                exp_slot = SW'(i);
            end
        end
        // full registry ignores newcomers
        do_register = seen_valid && !any_hit && free_found;
        expire.valid = exp_found;
        expire.neighbor = slot_id[exp_slot];
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            slot_valid <= '0;
        end else begin
            if (exp_found) begin
                slot_valid[exp_slot] <= 1'b0;
            end
            if (do_register) begin
                slot_valid[free_slot] <= 1'b1;
            end
        end
    end

    // liveness timers, saturating
    always_ff @(posedge nocclk) begin
        for (int i = 0; i < MAX_NEIGHBORS; i++) begin
            if (seen_valid && hit[i]) begin
                slot_timer[i] <= '0;
            end else if (slot_timer[i] != TIMER_MAX) begin
                slot_timer[i] <= slot_timer[i] + 1'b1;
            end
        end
        if (do_register) begin
            slot_id[free_slot] <= seen;
            slot_timer[free_slot] <= '0;
        end
    end

endmodule

//--- rtl/ingress_stage.sv
`timescale 1ns/1ns

module ingress_stage #(
    parameter noc_pkg::node_id_t NODE_ID = '0
) (
    input  logic                  nocclk,
    input  logic                  rst_n,

    input  noc_pkg::arrival_t     arrival,
    input  logic                  arrival_valid,
    output logic                  arrival_ready,
    input  logic                  advance,

    output noc_pkg::node_id_t     lookup_key,
    input  noc_pkg::route_entry_t route,
    output noc_pkg::route_entry_t learn,
    output noc_pkg::node_id_t     learn_dst,

    output noc_pkg::routed_flit_t out_flit,
    output logic                  out_valid,
    output logic                  out_local,
    output logic                  out_drop
);

    noc_pkg::arrival_t held;
    logic              held_valid;
    logic              fire;
    logic              is_data;
    logic              is_local;

    always_comb begin
        fire = held_valid && advance;
        is_data = held.flit.kind == noc_pkg::DATA;
        is_local = held.flit.dst == NODE_ID;
        arrival_ready = !held_valid || advance;

        lookup_key = held.flit.dst;

        // route announce teaches dst via the sender
        learn.valid = fire && held.flit.kind == noc_pkg::ROUTE_ADD;
        learn.next_hop = held.from_node;
        learn_dst = held.flit.dst;

        out_flit.flit = held.flit;
        out_flit.next_hop = is_local ? NODE_ID : route.next_hop;
        out_local = is_local;
        out_valid = fire && is_data && (is_local || route.valid);
        out_drop = fire && is_data && !is_local && !route.valid;
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (arrival_ready) begin
            held_valid <= arrival_valid;
        end
    end

    always_ff @(posedge nocclk) begin
        if (arrival_valid && arrival_ready) begin
            held <= arrival;
        end
    end

endmodule

//--- rtl/egress_steer.sv
`timescale 1ns/1ns

module egress_steer (
    input  logic                  nocclk,
    input  logic                  rst_n,

    input  noc_pkg::routed_flit_t in_flit,
    input  logic                  in_valid,
    input  logic                  in_local,
    input  logic                  in_drop,
    output logic                  in_ready,

    output noc_pkg::flit_t        local_flit,
    output logic                  local_valid,
    input  logic                  local_ready,

    output noc_pkg::routed_flit_t fwd_flit,
    output logic                  fwd_valid,
    input  logic                  fwd_ready,

    output noc_pkg::drop_count_t  drop_count
);

    noc_pkg::routed_flit_t out_q;
    logic                  out_valid_q;
    logic                  out_local_q;
    noc_pkg::drop_count_t  drop_q;
    logic                  sel_ready;

    // only the selected port can release the register
    always_comb begin
        sel_ready = out_local_q ? local_ready : fwd_ready;
        in_ready = !out_valid_q || sel_ready;

        local_flit = out_q.flit;
        local_valid = out_valid_q && out_local_q;
        fwd_flit = out_q;
        fwd_valid = out_valid_q && !out_local_q;
        drop_count = drop_q;
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            drop_q <= '0;
        end else begin
            if (in_ready) begin
                out_valid_q <= in_valid;
            end
            // counter wraps
            if (in_drop) begin
                drop_q <= drop_q + 1'b1;
            end
        end
    end

    always_ff @(posedge nocclk) begin
        if (in_valid && in_ready) begin
            out_q <= in_flit;
            out_local_q <= in_local;
        end
    end

    a_local_hold: assert property (@(posedge nocclk) disable iff (!rst_n)
        local_valid && !local_ready |=> local_valid && $stable(local_flit))
        else $error("local output changed before ready");

    a_fwd_hold: assert property (@(posedge nocclk) disable iff (!rst_n)
        fwd_valid && !fwd_ready |=> fwd_valid && $stable(fwd_flit))
        else $error("forward output changed before ready");

endmodule

//--- rtl/router_top.sv
`timescale 1ns/1ns

module router_top #(
    parameter noc_pkg::node_id_t NODE_ID = '0,
    parameter int EXPIRE_CYCLES = 200,
    parameter int MAX_NEIGHBORS = 8
) (
    input  logic                  nocclk,
    input  logic                  rst_n,

    input  noc_pkg::arrival_t     arrival,
    input  logic                  arrival_valid,
    output logic                  arrival_ready,

    output noc_pkg::flit_t        local_flit,
    output logic                  local_valid,
    input  logic                  local_ready,

    output noc_pkg::routed_flit_t fwd_flit,
    output logic                  fwd_valid,
    input  logic                  fwd_ready,

    output noc_pkg::drop_count_t  drop_count
);

    logic                  advance;
    logic                  seen_valid;
    logic                  egress_ready;
    noc_pkg::node_id_t     lookup_key;
    noc_pkg::route_entry_t route;
    noc_pkg::route_entry_t learn;
    noc_pkg::node_id_t     learn_dst;
    noc_pkg::expire_t      expire;
    noc_pkg::routed_flit_t ing_flit;
    logic                  ing_valid;
    logic                  ing_local;
    logic                  ing_drop;

    // whole pipeline holds while an expiry is applied
    always_comb begin
        advance = egress_ready && !expire.valid;
        seen_valid = arrival_valid && arrival_ready;
    end

    //////////////////////////////
    // datapath
    //////////////////////////////

    ingress_stage #(
        .NODE_ID(NODE_ID)
    ) ingress_stage_i (
        .nocclk       (nocclk),
        .rst_n        (rst_n),
        .arrival      (arrival),
        .arrival_valid(arrival_valid),
        .arrival_ready(arrival_ready),
        .advance      (advance),
        .lookup_key   (lookup_key),
        .route        (route),
        .learn        (learn),
        .learn_dst    (learn_dst),
        .out_flit     (ing_flit),
        .out_valid    (ing_valid),
        .out_local    (ing_local),
        .out_drop     (ing_drop)
    );

    egress_steer egress_steer_i (
        .nocclk     (nocclk),
        .rst_n      (rst_n),
        .in_flit    (ing_flit),
        .in_valid   (ing_valid),
        .in_local   (ing_local),
        .in_drop    (ing_drop),
        .in_ready   (egress_ready),
        .local_flit (local_flit),
        .local_valid(local_valid),
        .local_ready(local_ready),
        .fwd_flit   (fwd_flit),
        .fwd_valid  (fwd_valid),
        .fwd_ready  (fwd_ready),
        .drop_count (drop_count)
    );

    //////////////////////////////
    // routing state
    //////////////////////////////

    route_table route_table_i (
        .nocclk    (nocclk),
        .rst_n     (rst_n),
        .lookup_key(lookup_key),
        .route     (route),
        .learn     (learn),
        .learn_dst (learn_dst),
        .expire    (expire)
    );

    neighbor_monitor #(
        .EXPIRE_CYCLES(EXPIRE_CYCLES),
        .MAX_NEIGHBORS(MAX_NEIGHBORS)
    ) neighbor_monitor_i (
        .nocclk    (nocclk),
        .rst_n     (rst_n),
        .seen      (arrival.from_node),
        .seen_valid(seen_valid),
        .expire    (expire)
    );

endmodule

//--- test/router_tb_checks.svh
`ifndef ROUTER_TB_CHECKS_SVH
`define ROUTER_TB_CHECKS_SVH

// local port result
task automatic flit_check(
    input noc_pkg::flit_t got,
    input noc_pkg::flit_t exp,
    input string          what
);
    if (got !== exp) begin
        mismatch_stop({$sformatf("%s: got kind %0d src %0d dst %0d payload %h",
                                 what, got.kind, got.src, got.dst, got.payload),
                       $sformatf(", expected kind %0d src %0d dst %0d payload %h",
                                 exp.kind, exp.src, exp.dst, exp.payload)});
    end
endtask

// forward port result, next hop included
task automatic routed_check(
    input noc_pkg::routed_flit_t got,
    input noc_pkg::routed_flit_t exp,
    input string                 what
);
    if (got !== exp) begin
        mismatch_stop($sformatf("%s: got flit %h next_hop %0d, expected flit %h next_hop %0d",
                                what, got.flit, got.next_hop, exp.flit, exp.next_hop));
    end
endtask

task automatic drop_check(
    input noc_pkg::drop_count_t got,
    input noc_pkg::drop_count_t exp,
    input string                what
);
    if (got !== exp) begin
        mismatch_stop($sformatf("%s: drop_count %0d, expected %0d", what, got, exp));
    end
endtask

`endif

//--- test/router_tb.sv
`timescale 1ns/1ns

module router_tb;

    localparam noc_pkg::node_id_t NODE_ID = 4'd9;
    localparam int EXPIRE_CYCLES = 200;
    localparam int SEED = 61;
    localparam int SEND_LIMIT = 1000;
    localparam int DRAIN_LIMIT = 2000;
    localparam int BURST_FLITS = 16;
    localparam int PRESSURE_FLITS = 60;

    typedef enum logic [1:0] {
        GO_LOCAL,
        GO_FWD,
        GO_DROP,
        GO_LEARN
    } outcome_e;

    typedef struct packed {
        outcome_e              outcome;
        logic                  timed;
        logic [31:0]           accepted;
        noc_pkg::routed_flit_t flit;
    } expect_t;

    logic                  nocclk;
    logic                  rst_n;
    noc_pkg::arrival_t     arrival;
    logic                  arrival_valid;
    logic                  arrival_ready;
    noc_pkg::flit_t        local_flit;
    logic                  local_valid;
    logic                  local_ready;
    noc_pkg::routed_flit_t fwd_flit;
    logic                  fwd_valid;
    logic                  fwd_ready;
    noc_pkg::drop_count_t  drop_count;

    expect_t              exp_q [$];
    noc_pkg::drop_count_t exp_drops;
    int unsigned          cyc = 0;
    logic                 timed_phase;
    logic                 rand_ready;

    // reference table and neighbor liveness
    logic              model_valid [noc_pkg::NUM_NODES];
    noc_pkg::node_id_t model_hop [noc_pkg::NUM_NODES];
    logic              nb_live [noc_pkg::NUM_NODES];
    int unsigned       nb_last [noc_pkg::NUM_NODES];

    router_top #(
        .NODE_ID      (NODE_ID),
        .EXPIRE_CYCLES(EXPIRE_CYCLES),
        .MAX_NEIGHBORS(8)
    ) router_top_i (
        .nocclk       (nocclk),
        .rst_n        (rst_n),
        .arrival      (arrival),
        .arrival_valid(arrival_valid),
        .arrival_ready(arrival_ready),
        .local_flit   (local_flit),
        .local_valid  (local_valid),
        .local_ready  (local_ready),
        .fwd_flit     (fwd_flit),
        .fwd_valid    (fwd_valid),
        .fwd_ready    (fwd_ready),
        .drop_count   (drop_count)
    );

    task automatic mismatch_stop(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    task automatic abort_with(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    `include "router_tb_checks.svh"

    initial begin
        nocclk = 1'b0;
        forever #50 nocclk = ~nocclk;
    end

    always @(posedge nocclk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////
    // reference model
    ////////////////////////////////

    function automatic expect_t predict(input noc_pkg::arrival_t a, input int unsigned now);
        expect_t           e;
        noc_pkg::node_id_t dst;
        dst = a.flit.dst;
        // silent neighbors take their routes with them
        for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
            if (nb_live[n] && now - nb_last[n] > EXPIRE_CYCLES) begin
                nb_live[n] = 1'b0;
                for (int d = 0; d < noc_pkg::NUM_NODES; d++) begin
                    if (model_hop[d] == noc_pkg::node_id_t'(n)) begin
                        model_valid[d] = 1'b0;
                    end
                end
            end
        end
        nb_live[a.from_node] = 1'b1;
        nb_last[a.from_node] = now;
        e.timed = timed_phase;
        e.accepted = now;
        e.flit.flit = a.flit;
        e.flit.next_hop = NODE_ID;
        if (a.flit.kind == noc_pkg::ROUTE_ADD) begin
            model_valid[dst] = 1'b1;
            model_hop[dst] = a.from_node;
            e.outcome = GO_LEARN;
        end else if (dst == NODE_ID) begin
            e.outcome = GO_LOCAL;
        end else if (model_valid[dst]) begin
            e.outcome = GO_FWD;
            e.flit.next_hop = model_hop[dst];
        end else begin
            e.outcome = GO_DROP;
        end
        return e;
    endfunction

    function automatic noc_pkg::arrival_t make_arrival(
        input noc_pkg::flit_kind_e kind,
        input noc_pkg::node_id_t   dst,
        input noc_pkg::node_id_t   from
    );
        noc_pkg::arrival_t a;
        a.flit.kind = kind;
        a.flit.src = noc_pkg::node_id_t'($urandom);
        a.flit.dst = dst;
        a.flit.payload = 16'($urandom);
        a.from_node = from;
        return a;
    endfunction

    // routed, local and unroutable destinations
    function automatic noc_pkg::node_id_t dst_choice();
        case ($urandom % 6)
            0: return 4'd2;
            1: return 4'd7;
            2: return 4'd12;
            3: return NODE_ID;
            4: return 4'd0;
            default: return 4'd14;
        endcase
    endfunction

    function automatic noc_pkg::node_id_t neighbor_choice();
        return (($urandom % 2) == 0) ? 4'd3 : 4'd5;
    endfunction

    ////////////////////////////////
    // stimulus
    ////////////////////////////////

    task automatic send(input noc_pkg::arrival_t a);
        int      n;
        logic    taken;
        expect_t e;
        n = 0;
        taken = 1'b0;
        arrival <= a;
        arrival_valid <= 1'b1;
        while (!taken && n < SEND_LIMIT) begin
            @(posedge nocclk);
            n++;
            taken = arrival_ready;
        end
        if (!taken) begin
            abort_with("arrival channel stayed not ready");
        end else begin
            e = predict(a, cyc);
            if (e.outcome == GO_LOCAL || e.outcome == GO_FWD) begin
                exp_q.push_back(e);
            end else if (e.outcome == GO_DROP) begin
                exp_drops = exp_drops + 16'd1;
            end
        end
    endtask

    task automatic idle(input int cycles);
        arrival_valid <= 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge nocclk);
        end
    endtask

    task automatic drain(input string phase);
        int n;
        n = 0;
        arrival_valid <= 1'b0;
        while ((exp_q.size() != 0 || drop_count != exp_drops) && n < DRAIN_LIMIT) begin
            @(posedge nocclk);
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_with($sformatf("%s: %0d flits never came out", phase, exp_q.size()));
        end else begin
            drop_check(drop_count, exp_drops, phase);
        end
    endtask

    // output readies, random only while back-pressure runs
    initial begin
        local_ready = 1'b1;
        fwd_ready = 1'b1;
        forever begin
            @(posedge nocclk);
            if (rand_ready) begin
                local_ready <= ($urandom % 2) == 0;
                fwd_ready <= ($urandom % 3) != 0;
            end else begin
                local_ready <= 1'b1;
                fwd_ready <= 1'b1;
            end
        end
    end

    ////////////////////////////////
    // compare
    ////////////////////////////////

    task automatic take_output(input logic on_local);
        expect_t e;
        if (exp_q.size() == 0) begin
            mismatch_stop($sformatf("unexpected flit on the %s port",
                                    on_local ? "local" : "forward"));
        end else begin
            e = exp_q.pop_front();
            if ((e.outcome == GO_LOCAL) != on_local) begin
                mismatch_stop("flit came out on the wrong port");
            end else if (e.timed && cyc != e.accepted + 2) begin
                mismatch_stop($sformatf("latency %0d edges, expected 2", cyc - e.accepted));
            end else if (on_local) begin
                flit_check(local_flit, e.flit.flit, "local port");
            end else begin
                routed_check(fwd_flit, e.flit, "forward port");
            end
        end
    endtask

    always @(posedge nocclk) begin
        if (rst_n) begin
            if (local_valid && local_ready) begin
                take_output(1'b1);
            end
            if (fwd_valid && fwd_ready) begin
                take_output(1'b0);
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        arrival = '0;
        arrival_valid = 1'b0;
        rand_ready = 1'b0;
        timed_phase = 1'b0;
        exp_drops = '0;
        for (int i = 0; i < noc_pkg::NUM_NODES; i++) begin
            model_valid[i] = 1'b0;
            model_hop[i] = '0;
            nb_live[i] = 1'b0;
            nb_last[i] = 0;
        end
        repeat (10) @(posedge nocclk);
        rst_n <= 1'b1;

        timed_phase = 1'b1;
        for (int i = 0; i < BURST_FLITS; i++) begin
            send(make_arrival(noc_pkg::DATA, NODE_ID, neighbor_choice()));
        end
        drain("local delivery");

        send(make_arrival(noc_pkg::ROUTE_ADD, 4'd2, 4'd3));
        send(make_arrival(noc_pkg::ROUTE_ADD, 4'd7, 4'd5));
        send(make_arrival(noc_pkg::ROUTE_ADD, 4'd12, 4'd3));
        for (int i = 0; i < BURST_FLITS; i++) begin
            send(make_arrival(noc_pkg::DATA, dst_choice(), neighbor_choice()));
        end
        drain("forwarding");

        timed_phase = 1'b0;
        rand_ready <= 1'b1;
        for (int i = 0; i < PRESSURE_FLITS; i++) begin
            send(make_arrival(noc_pkg::DATA, dst_choice(), neighbor_choice()));
        end
        rand_ready <= 1'b0;
        drain("back-pressure");

        // neighbors 3 and 5 go silent and expire
        idle(3 * EXPIRE_CYCLES);
        send(make_arrival(noc_pkg::DATA, 4'd2, 4'd11));
        send(make_arrival(noc_pkg::DATA, 4'd7, 4'd11));
        send(make_arrival(noc_pkg::DATA, 4'd12, 4'd11));
        drain("expiry");

        send(make_arrival(noc_pkg::ROUTE_ADD, 4'd7, 4'd11));
        send(make_arrival(noc_pkg::ROUTE_ADD, 4'd2, 4'd3));
        for (int i = 0; i < BURST_FLITS; i++) begin
            send(make_arrival(noc_pkg::DATA, dst_choice(), (i % 2 == 0) ? 4'd11 : 4'd3));
        end
        drain("relearn");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- noc_router.f
+incdir+test
common/noc_pkg.sv
route/route_table.sv
route/neighbor_monitor.sv
rtl/ingress_stage.sv
rtl/egress_steer.sv
rtl/router_top.sv
test/router_tb.sv

//--- Makefile
TOP := router_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f noc_router.f \
		--top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f noc_router.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
